//--- hw/sa_num_pkg.sv
// Numeric widths and signed element types for the attention datapath
package sa_num_pkg;

	// Input samples and weights
	localparam int data_w = 8;

	// Q, K and V elements hold a sum of eight 8x8 products
	localparam int proj_w = 19;

	// Score elements hold a sum of eight 19x19 products
	localparam int score_w = 41;

	// Output element holds score times V summed over a row
	localparam int res_w = 64;

	typedef logic signed [data_w-1:0]  data_t;
	typedef logic signed [proj_w-1:0]  proj_t;
	typedef logic signed [score_w-1:0] score_t;
	typedef logic signed [res_w-1:0]   res_t;

endpackage

//--- hw/sa_ctrl_pkg.sv
// Job phase enumeration and load phase beat count
package sa_ctrl_pkg;

	// Phases of one job in the order they run
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_LOAD_X,
		PH_LOAD_K,
		PH_LOAD_V,
		PH_OUT
	} sa_phase_e;

	// One full 8x8 matrix per load phase
	localparam int beats_per_phase = 64;

endpackage

//--- hw/sa_sequencer.sv
// Phase FSM, row and column counters, job length capture
`timescale 1ns/1ps

module sa_sequencer #(
	parameter int dim = 8
) (
	input  logic                   k_clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  logic [3:0]             t_len,
	output sa_ctrl_pkg::sa_phase_e phase,
	output logic [2:0]             row,
	output logic [2:0]             col,
	output logic                   x_write
);
	import sa_ctrl_pkg::*;

	sa_phase_e  phase_nxt;
	logic [3:0] t_q;
	logic [2:0] row_last;
	logic       col_last;
	logic       beat_last;

	assign col_last = (col == 3'(dim - 1));

	// Output phase only walks the rows of the job
	assign row_last = (phase == PH_OUT) ? 3'(t_q - 4'd1) : 3'(dim - 1);

	// Load phases always take a full matrix of beats
	assign beat_last = (phase == PH_OUT) ? (col_last && (row == row_last))
		: ({row, col} == 6'(beats_per_phase - 1));

	// X rows past the job length are never written
	assign x_write = (phase == PH_LOAD_X) && ({1'b0, row} < t_q);

	always_comb begin
		phase_nxt = phase;
		case (phase)
			PH_IDLE: begin
				if (in_valid) begin
					phase_nxt = PH_LOAD_X;
				end
			end
			PH_LOAD_X: begin
				if (beat_last) begin
					phase_nxt = PH_LOAD_K;
				end
			end
			PH_LOAD_K: begin
				if (beat_last) begin
					phase_nxt = PH_LOAD_V;
				end
			end
			PH_LOAD_V: begin
				if (beat_last) begin
					phase_nxt = PH_OUT;
				end
			end
			PH_OUT: begin
				if (beat_last) begin
					phase_nxt = PH_IDLE;
				end
			end
			default: begin
				phase_nxt = PH_IDLE;
			end
		endcase
	end

	always_ff @(posedge k_clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_IDLE;
			t_q   <= 4'd8;
			row   <= '0;
			col   <= '0;
		end else begin
			phase <= phase_nxt;
			if (phase == PH_IDLE) begin
				// Length taken from the first beat
				if (in_valid) begin
					t_q <= t_len;
				end
				row <= '0;
				col <= '0;
			end else begin
				col <= col_last ? 3'd0 : col + 3'd1;
				if (col_last) begin
					row <= (row == row_last) ? 3'd0 : row + 3'd1;
				end
			end
		end
	end

endmodule

//--- hw/sa_load_stage.sv
// Input beat registers, X and Wq storage, row and column selection
`timescale 1ns/1ps

module sa_load_stage #(
	parameter int dim = 8
) (
	input  logic                   k_clk,
	input  logic                   rst_n,
	input  sa_num_pkg::data_t      in_data,
	input  sa_num_pkg::data_t      w_q,
	input  sa_ctrl_pkg::sa_phase_e phase,
	input  logic [2:0]             row,
	input  logic [2:0]             col,
	input  logic                   x_write,
	output sa_num_pkg::data_t      x_row [dim],
	output sa_num_pkg::data_t      x_col [dim],
	output sa_num_pkg::data_t      wq_col [dim]
);
	import sa_num_pkg::*;
	import sa_ctrl_pkg::*;

	data_t in_q;
	data_t wq_in_q;
	data_t x_mem [dim][dim];
	data_t wq_mem [dim][dim];

	// Beat is stored one cycle after it is sampled
	always_ff @(posedge k_clk) begin
		in_q    <= in_data;
		wq_in_q <= w_q;
	end

	always_ff @(posedge k_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < dim; i++) begin
				for (int j = 0; j < dim; j++) begin
					x_mem[i][j] <= '0;
				end
			end
		end else if (phase == PH_OUT) begin
			// Cleared while the result streams out so a shorter job sees zero rows
			for (int i = 0; i < dim; i++) begin
				for (int j = 0; j < dim; j++) begin
					x_mem[i][j] <= '0;
				end
			end
		end else if (x_write) begin
			x_mem[row][col] <= in_q;
		end
	end

	always_ff @(posedge k_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < dim; i++) begin
				for (int j = 0; j < dim; j++) begin
					wq_mem[i][j] <= '0;
				end
			end
		end else if (phase == PH_LOAD_X) begin
			wq_mem[row][col] <= wq_in_q;
		end
	end

	// X column is picked by row, which is the Wk or Wv row index in later phases
	always_comb begin
		for (int i = 0; i < dim; i++) begin
			x_row[i]  = x_mem[row][i];
			x_col[i]  = x_mem[i][row];
			wq_col[i] = wq_mem[i][col];
		end
	end

endmodule

//--- hw/sa_proj_stage.sv
// Q, K and V projection storage with shared multipliers and accumulators
`timescale 1ns/1ps

module sa_proj_stage #(
	parameter int dim = 8
) (
	input  logic                   k_clk,
	input  logic                   rst_n,
	input  sa_num_pkg::data_t      w_k,
	input  sa_num_pkg::data_t      w_v,
	input  sa_ctrl_pkg::sa_phase_e phase,
	input  logic [2:0]             row,
	input  logic [2:0]             col,
	input  sa_num_pkg::data_t      x_row [dim],
	input  sa_num_pkg::data_t      x_col [dim],
	input  sa_num_pkg::data_t      wq_col [dim],
	output sa_num_pkg::proj_t      q_row [dim],
	output sa_num_pkg::proj_t      k_row [dim],
	output sa_num_pkg::proj_t      v_col [dim]
);
	import sa_num_pkg::*;
	import sa_ctrl_pkg::*;

	data_t wk_q;
	data_t wv_q;
	data_t w_mul;
	proj_t prod [dim];
	proj_t q_dot;
	proj_t q_mem [dim][dim];
	proj_t k_mem [dim][dim];
	proj_t v_mem [dim][dim];

	always_ff @(posedge k_clk) begin
		wk_q <= w_k;
		wv_q <= w_v;
	end

	// One column of products serves K in its phase and V in the next
	assign w_mul = (phase == PH_LOAD_V) ? wv_q : wk_q;

	always_comb begin
		for (int i = 0; i < dim; i++) begin
			prod[i] = x_col[i] * w_mul;
		end
	end

	// Full dot product for one Q element per cycle
	always_comb begin
		q_dot = '0;
		for (int j = 0; j < dim; j++) begin
			q_dot = q_dot + x_row[j] * wq_col[j];
		end
	end

	always_ff @(posedge k_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < dim; i++) begin
				for (int j = 0; j < dim; j++) begin
					q_mem[i][j] <= '0;
					k_mem[i][j] <= '0;
					v_mem[i][j] <= '0;
				end
			end
		end else begin
			case (phase)
				PH_IDLE: begin
					for (int i = 0; i < dim; i++) begin
						for (int j = 0; j < dim; j++) begin
							q_mem[i][j] <= '0;
							k_mem[i][j] <= '0;
							v_mem[i][j] <= '0;
						end
					end
				end
				PH_LOAD_K: begin
					q_mem[row][col] <= q_dot;
					// K[i][col] gains X[i][row] * Wk[row][col]
					for (int i = 0; i < dim; i++) begin
						k_mem[i][col] <= k_mem[i][col] + prod[i];
					end
				end
				PH_LOAD_V: begin
					for (int i = 0; i < dim; i++) begin
						v_mem[i][col] <= v_mem[i][col] + prod[i];
					end
				end
				default: begin
				end
			endcase
		end
	end

	// K is read by row at the column index, as needed for Q times K transposed
	always_comb begin
		for (int i = 0; i < dim; i++) begin
			q_row[i] = q_mem[row][i];
			k_row[i] = k_mem[col][i];
			v_col[i] = v_mem[i][col];
		end
	end

endmodule

//--- hw/sa_attend_stage.sv
// Score computation with ReLU and divide by 3, score storage, output dot product
`timescale 1ns/1ps

module sa_attend_stage #(
	parameter int dim = 8
) (
	input  logic                   k_clk,
	input  logic                   rst_n,
	input  sa_ctrl_pkg::sa_phase_e phase,
	input  logic [2:0]             row,
	input  logic [2:0]             col,
	input  sa_num_pkg::proj_t      q_row [dim],
	input  sa_num_pkg::proj_t      k_row [dim],
	input  sa_num_pkg::proj_t      v_col [dim],
	output logic                   out_valid,
	output sa_num_pkg::res_t       out_data
);
	import sa_num_pkg::*;
	import sa_ctrl_pkg::*;

	score_t s_dot;
	score_t s_val;
	res_t   out_dot;
	score_t s_mem [dim][dim];

	// Q row dotted with K row gives one score
	always_comb begin
		s_dot = '0;
		for (int j = 0; j < dim; j++) begin
			s_dot = s_dot + q_row[j] * k_row[j];
		end
	end

	// Negative scores drop to zero and the rest are scaled down with truncation
	assign s_val = s_dot[score_w-1] ? score_t'(0) : s_dot / score_t'(3);

	always_ff @(posedge k_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < dim; i++) begin
				for (int j = 0; j < dim; j++) begin
					s_mem[i][j] <= '0;
				end
			end
		end else if (phase == PH_IDLE) begin
			for (int i = 0; i < dim; i++) begin
				for (int j = 0; j < dim; j++) begin
					s_mem[i][j] <= '0;
				end
			end
		end else if (phase == PH_LOAD_V) begin
			s_mem[row][col] <= s_val;
		end
	end

	// Output element at row, col is S row times V column
	always_comb begin
		out_dot = '0;
		for (int j = 0; j < dim; j++) begin
			out_dot = out_dot + s_mem[row][j] * v_col[j];
		end
	end

	assign out_valid = (phase == PH_OUT);
	assign out_data  = out_valid ? out_dot : res_t'(0);

endmodule

//--- hw/sa_top.sv
// Attention engine top level with sequencer and three datapath stages
`timescale 1ns/1ps

module sa_top #(
	parameter int dim = 8
) (
	input  logic              k_clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  logic [3:0]        t_len,
	input  sa_num_pkg::data_t in_data,
	input  sa_num_pkg::data_t w_q,
	input  sa_num_pkg::data_t w_k,
	input  sa_num_pkg::data_t w_v,
	output logic              out_valid,
	output sa_num_pkg::res_t  out_data
);
	import sa_num_pkg::*;
	import sa_ctrl_pkg::*;

	sa_phase_e  phase;
	logic [2:0] row;
	logic [2:0] col;
	logic       x_write;
	data_t      x_row [dim];
	data_t      x_col [dim];
	data_t      wq_col [dim];
	proj_t      q_row [dim];
	proj_t      k_row [dim];
	proj_t      v_col [dim];

	sa_sequencer #(
		.dim(dim)
	) i_sequencer (
		.k_clk    (k_clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.t_len    (t_len),
		.phase    (phase),
		.row      (row),
		.col      (col),
		.x_write  (x_write)
	);

	sa_load_stage #(
		.dim(dim)
	) i_load_stage (
		.k_clk   (k_clk),
		.rst_n   (rst_n),
		.in_data (in_data),
		.w_q     (w_q),
		.phase   (phase),
		.row     (row),
		.col     (col),
		.x_write (x_write),
		.x_row   (x_row),
		.x_col   (x_col),
		.wq_col  (wq_col)
	);

	sa_proj_stage #(
		.dim(dim)
	) i_proj_stage (
		.k_clk  (k_clk),
		.rst_n  (rst_n),
		.w_k    (w_k),
		.w_v    (w_v),
		.phase  (phase),
		.row    (row),
		.col    (col),
		.x_row  (x_row),
		.x_col  (x_col),
		.wq_col (wq_col),
		.q_row  (q_row),
		.k_row  (k_row),
		.v_col  (v_col)
	);

	sa_attend_stage #(
		.dim(dim)
	) i_attend_stage (
		.k_clk     (k_clk),
		.rst_n     (rst_n),
		.phase     (phase),
		.row       (row),
		.col       (col),
		.q_row     (q_row),
		.k_row     (k_row),
		.v_col     (v_col),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

//--- dv/sa_clk_gen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ps

module sa_clk_gen #(
	parameter int period_ns  = 4,
	parameter int rst_cycles = 5
) (
	output logic k_clk,
	output logic rst_n
);

	initial begin
		k_clk = 1'b0;
		forever #(period_ns / 2) k_clk = ~k_clk;
	end

	// Reset released on a rising edge after the low period
	initial begin
		rst_n = 1'b0;
		repeat (rst_cycles) @(posedge k_clk);
		rst_n <= 1'b1;
	end

endmodule

//--- dv/sa_top_sva.sv
// Port assertions for the attention engine top level and their bind into sa_top
`timescale 1ns/1ps

module sa_top_sva (
	input logic             k_clk,
	input logic             rst_n,
	input logic             out_valid,
	input sa_num_pkg::res_t out_data
);
	import sa_num_pkg::*;

	// Output bus is quiet between result streams
	property p_data_zero_when_idle;
		@(posedge k_clk) disable iff (!rst_n)
			!out_valid |-> (out_data == res_t'(0));
	endproperty

	property p_valid_known;
		@(posedge k_clk) disable iff (!rst_n)
			!$isunknown(out_valid);
	endproperty

	a_data_zero_when_idle: assert property (p_data_zero_when_idle)
		else $error("out_data is nonzero while out_valid is low");

	a_valid_known: assert property (p_valid_known)
		else $error("out_valid has an unknown value after reset");

endmodule

bind sa_top sa_top_sva i_sva (
	.k_clk     (k_clk),
	.rst_n     (rst_n),
	.out_valid (out_valid),
	.out_data  (out_data)
);

//--- dv/sa_tb.sv
// Attention engine testbench with reference model, output checks and test report
`timescale 1ns/1ps

module sa_tb;
	import sa_num_pkg::*;

	logic       k_clk;
	logic       rst_n;
	logic       in_valid;
	logic [3:0] t_len;
	data_t      in_data;
	data_t      w_q;
	data_t      w_k;
	data_t      w_v;
	logic       out_valid;
	res_t       out_data;

	// Two matrix sets so that a second job can be prepared while the first runs
	int   x_m [2][8][8];
	int   wq_m [2][8][8];
	int   wk_m [2][8][8];
	int   wv_m [2][8][8];
	res_t exp_q [$];
	int   out_idx;
	logic exp_ok;
	res_t exp_now;
	int   err_cnt;
	int   test_cnt;
	int   test_fail;

	sa_clk_gen #(
		.period_ns  (4),
		.rst_cycles (5)
	) i_clk_gen (
		.k_clk (k_clk),
		.rst_n (rst_n)
	);

	sa_top #(
		.dim(8)
	) i_dut (
		.k_clk     (k_clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.t_len     (t_len),
		.in_data   (in_data),
		.w_q       (w_q),
		.w_k       (w_k),
		.w_v       (w_v),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	// Expected element for the next cycle stays stable until the following edge
	always @(posedge k_clk) begin
		int nxt;
		nxt = out_idx + (out_valid ? 1 : 0);
		out_idx <= nxt;
		exp_ok  <= (nxt < exp_q.size());
		exp_now <= (nxt < exp_q.size()) ? exp_q[nxt] : res_t'(0);
	end

	a_out_match: assert property (@(negedge k_clk) disable iff (!rst_n)
		out_valid |-> (exp_ok && (out_data == exp_now)))
		else begin
			$display("Fail at %0t: out_data %0d, expected %0d", $time, out_data, exp_now);
			err_cnt++;
		end

	function automatic int rnd(int lo, int hi);
		return lo + int'($urandom_range(hi - lo));
	endfunction

	task automatic fill_job(int s, int xlo, int xhi, int wlo, int whi);
		for (int i = 0; i < 8; i++) begin
			for (int j = 0; j < 8; j++) begin
				x_m[s][i][j]  = rnd(xlo, xhi);
				wq_m[s][i][j] = rnd(wlo, whi);
				wk_m[s][i][j] = rnd(wlo, whi);
				wv_m[s][i][j] = rnd(wlo, whi);
			end
		end
	endtask

	// Reference model with projections from the first t rows, ReLU and truncating divide by 3
	function automatic void push_expected(int s, int t);
		longint q [8][8];
		longint k [8][8];
		longint v [8][8];
		longint sc [8][8];
		longint acc;
		for (int i = 0; i < 8; i++) begin
			for (int j = 0; j < 8; j++) begin
				q[i][j] = 0;
				k[i][j] = 0;
				v[i][j] = 0;
				for (int m = 0; m < 8; m++) begin
					if (i < t) begin
						q[i][j] += longint'(x_m[s][i][m] * wq_m[s][m][j]);
						k[i][j] += longint'(x_m[s][i][m] * wk_m[s][m][j]);
						v[i][j] += longint'(x_m[s][i][m] * wv_m[s][m][j]);
					end
				end
			end
		end
		for (int i = 0; i < 8; i++) begin
			for (int j = 0; j < 8; j++) begin
				acc = 0;
				for (int m = 0; m < 8; m++) begin
					acc += q[i][m] * k[j][m];
				end
				sc[i][j] = (acc < 0) ? 0 : acc / 3;
			end
		end
		for (int i = 0; i < t; i++) begin
			for (int c = 0; c < 8; c++) begin
				acc = 0;
				for (int j = 0; j < 8; j++) begin
					acc += sc[i][j] * v[j][c];
				end
				exp_q.push_back(res_t'(acc));
			end
		end
	endfunction

	task automatic end_run();
		$display("tests run %0d, tests failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
		if (err_cnt == 0 && test_fail == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	// Called right after a rising edge and returns on the edge of the last output
	task automatic run_job(int s, int t);
		int   lat;
		int   cnt;
		logic seen;
		logic run;
		t_len <= 4'(t);
		for (int b = 0; b < 192; b++) begin
			in_valid <= 1'b1;
			in_data  <= data_t'(x_m[s][(b % 64) / 8][b % 8]);
			w_q      <= data_t'(wq_m[s][(b % 64) / 8][b % 8]);
			w_k      <= data_t'(wk_m[s][(b % 64) / 8][b % 8]);
			w_v      <= data_t'(wv_m[s][(b % 64) / 8][b % 8]);
			@(posedge k_clk);
		end
		in_valid <= 1'b0;
		// This edge sampled beat 191
		lat  = 191;
		seen = 1'b0;
		while (!seen && lat < 400) begin
			@(posedge k_clk);
			lat++;
			seen = out_valid;
		end
		if (!seen) begin
			$display("Timed out waiting for out_valid after the first beat");
			err_cnt++;
		end else begin
			assert (lat == 193) else begin
				$display("Fail at %0t: first output %0d cycles after the first beat, expected 193",
					$time, lat);
				err_cnt++;
			end
			cnt = 1;
			run = 1'b1;
			while (run && cnt < t * 8 && cnt < 100) begin
				@(posedge k_clk);
				if (out_valid) begin
					cnt++;
				end else begin
					run = 1'b0;
				end
			end
			assert (cnt == t * 8) else begin
				$display("Fail at %0t: %0d contiguous outputs, expected %0d", $time, cnt, t * 8);
				err_cnt++;
			end
		end
	endtask

	task automatic check_end();
		@(posedge k_clk);
		assert (!out_valid) else begin
			$display("Fail at %0t: out_valid still high after the last output", $time);
			err_cnt++;
		end
	endtask

	task automatic report(string name, int errs_before);
		test_cnt++;
		if (err_cnt != errs_before) begin
			test_fail++;
		end
		$display("test %0d %s: %s", test_cnt, name, (err_cnt == errs_before) ? "ok" : "FAILED");
	endtask

	task automatic run_tests();
		int e;
		int r;

		// Idle after reset
		e = err_cnt;
		for (int c = 0; c < 20; c++) begin
			@(posedge k_clk);
			assert (!out_valid && out_data == res_t'(0)) else begin
				$display("Fail at %0t: output active while idle", $time);
				err_cnt++;
			end
		end
		report("idle after reset", e);

		e = err_cnt;
		fill_job(0, -128, 127, -128, 127);
		push_expected(0, 8);
		run_job(0, 8);
		check_end();
		report("random job T=8", e);

		// Rows past T carry nonzero data that must not count
		e = err_cnt;
		fill_job(0, 1, 127, -128, 127);
		push_expected(0, 3);
		run_job(0, 3);
		check_end();
		report("job T=3 with extra rows", e);

		// Identical X rows and Wk = -Wq make every score negative
		e = err_cnt;
		fill_job(0, 1, 20, -100, 100);
		for (int i = 0; i < 8; i++) begin
			for (int j = 0; j < 8; j++) begin
				x_m[0][i][j]  = x_m[0][0][j];
				wk_m[0][i][j] = -wq_m[0][i][j];
			end
		end
		push_expected(0, 8);
		run_job(0, 8);
		check_end();
		report("negative scores clamp", e);

		e = err_cnt;
		fill_job(0, 0, 2, 0, 2);
		push_expected(0, 8);
		run_job(0, 8);
		check_end();
		report("small scores truncate", e);

		e = err_cnt;
		r = rnd(1, 8);
		fill_job(0, -128, 127, -128, 127);
		push_expected(0, r);
		run_job(0, r);
		check_end();
		report($sformatf("latency and length T=%0d", r), e);

		// Second job starts in the first idle cycle after the first
		e = err_cnt;
		fill_job(0, -128, 127, -128, 127);
		fill_job(1, -128, 127, -128, 127);
		push_expected(0, 7);
		push_expected(1, 2);
		run_job(0, 7);
		run_job(1, 2);
		check_end();
		report("back to back T=7 then T=2", e);
	endtask

	// Overall cycle limit
	initial begin
		int n;
		n = 0;
		while (n < 20000) begin
			@(posedge k_clk);
			n++;
		end
		$display("Run did not finish within %0d cycles", n);
		err_cnt++;
		end_run();
	end

	initial begin
		int n;
		in_valid  = 1'b0;
		t_len     = 4'd8;
		in_data   = '0;
		w_q       = '0;
		w_k       = '0;
		w_v       = '0;
		out_idx   = 0;
		exp_ok    = 1'b0;
		exp_now   = '0;
		err_cnt   = 0;
		test_cnt  = 0;
		test_fail = 0;
		void'($urandom(41));

		n = 0;
		while (!rst_n && n < 50) begin
			@(posedge k_clk);
			n++;
		end
		if (!rst_n) begin
			$display("Reset was never released");
			err_cnt++;
		end else begin
			run_tests();
		end
		end_run();
	end

endmodule

//--- all.f
hw/sa_num_pkg.sv
hw/sa_ctrl_pkg.sv
hw/sa_sequencer.sv
hw/sa_load_stage.sv
hw/sa_proj_stage.sv
hw/sa_attend_stage.sv
hw/sa_top.sv
dv/sa_clk_gen.sv
dv/sa_top_sva.sv
dv/sa_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then search the log for failure
rm -f sim.log
( verilator --binary --timing --assert -f all.f --top-module sa_tb -o sa_sim \
	&& ./obj_dir/sa_sim > sim.log 2>&1 ) \
	|| echo "Simulation finished: FAIL" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0
